//--- cce_pkg.sv
//**********************************************************
// shared definitions for the CCE microcode decoder:
// widths, major and minor opcode encodings, operand-format
// union, instruction word and decoded control word
//**********************************************************

package cce_pkg;

  // instruction and datapath widths
  localparam int inst_width    = 32;
  localparam int pc_width      = 8;
  localparam int opd_width     = 4;
  localparam int gpr_sel_width = 3;
  localparam int num_gpr       = 8;
  localparam int num_flags     = 16;
  localparam int num_special   = 16;
  localparam int imm16_width   = 16;
  localparam int imm8_width    = 8;

  // major opcode, anything above reg_data is invalid
  typedef enum logic [2:0] {
    e_op_alu      = 3'd0,
    e_op_branch   = 3'd1,
    e_op_reg_data = 3'd2
  } cce_op_e;

  typedef logic [3:0] cce_minor_op_t;

  // operand field is what remains after op, minor op, branch and predict bits
  localparam int opd_fmt_width = inst_width - $bits(cce_op_e) - $bits(cce_minor_op_t) - 2;

  localparam int rtype_pad_width  = opd_fmt_width - 3 * opd_width;
  localparam int itype_pad_width  = opd_fmt_width - opd_width - imm16_width;
  localparam int btype_pad_width  = opd_fmt_width - pc_width - 2 * opd_width;
  localparam int bitype_pad_width = opd_fmt_width - pc_width - opd_width - imm8_width;

  // alu minor opcodes
  localparam cce_minor_op_t e_add_op  = 4'd0;
  localparam cce_minor_op_t e_sub_op  = 4'd1;
  localparam cce_minor_op_t e_lsh_op  = 4'd2;
  localparam cce_minor_op_t e_rsh_op  = 4'd3;
  localparam cce_minor_op_t e_and_op  = 4'd4;
  localparam cce_minor_op_t e_or_op   = 4'd5;
  localparam cce_minor_op_t e_xor_op  = 4'd6;
  localparam cce_minor_op_t e_neg_op  = 4'd7;
  localparam cce_minor_op_t e_addi_op = 4'd8;
  localparam cce_minor_op_t e_subi_op = 4'd9;
  localparam cce_minor_op_t e_lshi_op = 4'd10;
  localparam cce_minor_op_t e_rshi_op = 4'd11;
  localparam cce_minor_op_t e_not_op  = 4'd12;

  // branch minor opcodes
  localparam cce_minor_op_t e_beq_op  = 4'd0;
  localparam cce_minor_op_t e_bne_op  = 4'd1;
  localparam cce_minor_op_t e_blt_op  = 4'd2;
  localparam cce_minor_op_t e_ble_op  = 4'd3;
  localparam cce_minor_op_t e_bs_op   = 4'd4;
  localparam cce_minor_op_t e_bss_op  = 4'd5;
  localparam cce_minor_op_t e_beqi_op = 4'd6;
  localparam cce_minor_op_t e_bsi_op  = 4'd7;

  // register data move minor opcodes
  localparam cce_minor_op_t e_mov_op   = 4'd0;
  localparam cce_minor_op_t e_movsg_op = 4'd1;
  localparam cce_minor_op_t e_movgs_op = 4'd2;
  localparam cce_minor_op_t e_movfg_op = 4'd3;
  localparam cce_minor_op_t e_movgf_op = 4'd4;
  localparam cce_minor_op_t e_movi_op  = 4'd5;
  localparam cce_minor_op_t e_movis_op = 4'd6;
  localparam cce_minor_op_t e_clm_op   = 4'd7;

  typedef enum logic [3:0] {
    e_alu_none,
    e_alu_add,
    e_alu_sub,
    e_alu_lsh,
    e_alu_rsh,
    e_alu_and,
    e_alu_or,
    e_alu_xor,
    e_alu_neg,
    e_alu_not
  } cce_alu_op_e;

  typedef enum logic [1:0] {
    e_branch_eq,
    e_branch_neq,
    e_branch_lt,
    e_branch_le
  } cce_branch_op_e;

  typedef enum logic [2:0] {
    e_src_sel_none,
    e_src_sel_gpr,
    e_src_sel_imm,
    e_src_sel_special,
    e_src_sel_flag
  } cce_src_sel_e;

  typedef enum logic [1:0] {
    e_dst_sel_none,
    e_dst_sel_gpr,
    e_dst_sel_special,
    e_dst_sel_flag
  } cce_dst_sel_e;

  // special operand numbers
  localparam logic [opd_width-1:0] opd_req_lce  = 4'd0;
  localparam logic [opd_width-1:0] opd_req_addr = 4'd1;
  localparam logic [opd_width-1:0] opd_flags    = 4'd8;

  // operand formats, all the same width
  typedef struct packed {
    logic [opd_width-1:0]       dst;
    logic [opd_width-1:0]       src_a;
    logic [opd_width-1:0]       src_b;
    logic [rtype_pad_width-1:0] pad;
  } cce_rtype_s;

  typedef struct packed {
    logic [opd_width-1:0]       dst;
    logic [imm16_width-1:0]     imm16;
    logic [itype_pad_width-1:0] pad;
  } cce_itype_s;

  typedef struct packed {
    logic [pc_width-1:0]        target;
    logic [opd_width-1:0]       src_a;
    logic [opd_width-1:0]       src_b;
    logic [btype_pad_width-1:0] pad;
  } cce_btype_s;

  typedef struct packed {
    logic [pc_width-1:0]         target;
    logic [opd_width-1:0]        src_a;
    logic [imm8_width-1:0]       imm8;
    logic [bitype_pad_width-1:0] pad;
  } cce_bitype_s;

  typedef union packed {
    cce_rtype_s  rtype;
    cce_itype_s  itype;
    cce_btype_s  btype;
    cce_bitype_s bitype;
  } cce_opd_u;

  typedef struct packed {
    cce_op_e       op;
    cce_minor_op_t minor_op;
    logic          branch;
    logic          predict_taken;
    cce_opd_u      opd;
  } cce_inst_s;

  typedef struct packed {
    logic                   v;
    logic                   branch;
    logic                   predict_taken;
    cce_op_e                op;
    cce_minor_op_t          minor_op;
    cce_alu_op_e            alu_op;
    cce_branch_op_e         branch_op;
    cce_src_sel_e           src_a_sel;
    logic [opd_width-1:0]   src_a;
    cce_src_sel_e           src_b_sel;
    logic [opd_width-1:0]   src_b;
    cce_dst_sel_e           dst_sel;
    logic [opd_width-1:0]   dst;
    logic [imm16_width-1:0] imm;
    logic [pc_width-1:0]    branch_target;
    logic [num_gpr-1:0]     gpr_w_v;
    logic [num_flags-1:0]   flag_w_v;
    logic [num_special-1:0] special_w_v;
    logic                   mshr_clear;
  } cce_decoded_s;

endpackage

//--- cce_stage_reg.sv
//**********************************************************
// execute-stage register for instruction, PC and valid bit
// stall holds all three, mispredict squashes the next valid
//**********************************************************

`timescale 1ns/1ps

module cce_stage_reg (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  cce_pkg::cce_inst_s           inst_i,
  input  logic [cce_pkg::pc_width-1:0] pc_i,
  input  logic                         inst_v_i,
  input  logic                         stall_i,
  input  logic                         mispredict_i,
  output cce_pkg::cce_inst_s           inst_o,
  output logic [cce_pkg::pc_width-1:0] pc_o,
  output logic                         inst_v_o
);

  logic inst_v_n;

  // the fetch-stage word is still loaded on a mispredict, only its valid drops
  assign inst_v_n = inst_v_i & ~mispredict_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      inst_o   <= '0;
      pc_o     <= '0;
      inst_v_o <= 1'b0;
    end else if (!stall_i) begin
      inst_o   <= inst_i;
      pc_o     <= pc_i;
      inst_v_o <= inst_v_n;
    end
    // stall keeps everything so the same instruction replays
  end

endmodule

//--- cce_alu_decode.sv
//**********************************************************
// ALU class decoder
// minor opcode to ALU function, source selects and the
// one-hot GPR write enable
//**********************************************************

`timescale 1ns/1ps

module cce_alu_decode (
  input  cce_pkg::cce_inst_s    inst_i,
  output cce_pkg::cce_decoded_s decoded_o
);

  cce_pkg::cce_alu_op_e alu_op;
  logic                 reg_form;
  logic                 imm_form;

  always_comb begin
    alu_op   = cce_pkg::e_alu_none;
    reg_form = 1'b0;
    imm_form = 1'b0;
    case (inst_i.minor_op)
      cce_pkg::e_add_op: begin
        alu_op   = cce_pkg::e_alu_add;
        reg_form = 1'b1;
      end
      cce_pkg::e_sub_op: begin
        alu_op   = cce_pkg::e_alu_sub;
        reg_form = 1'b1;
      end
      cce_pkg::e_lsh_op: begin
        alu_op   = cce_pkg::e_alu_lsh;
        reg_form = 1'b1;
      end
      cce_pkg::e_rsh_op: begin
        alu_op   = cce_pkg::e_alu_rsh;
        reg_form = 1'b1;
      end
      cce_pkg::e_and_op: begin
        alu_op   = cce_pkg::e_alu_and;
        reg_form = 1'b1;
      end
      cce_pkg::e_or_op: begin
        alu_op   = cce_pkg::e_alu_or;
        reg_form = 1'b1;
      end
      cce_pkg::e_xor_op: begin
        alu_op   = cce_pkg::e_alu_xor;
        reg_form = 1'b1;
      end
      cce_pkg::e_addi_op: begin
        alu_op   = cce_pkg::e_alu_add;
        imm_form = 1'b1;
      end
      cce_pkg::e_subi_op: begin
        alu_op   = cce_pkg::e_alu_sub;
        imm_form = 1'b1;
      end
      cce_pkg::e_lshi_op: begin
        alu_op   = cce_pkg::e_alu_lsh;
        imm_form = 1'b1;
      end
      cce_pkg::e_rshi_op: begin
        alu_op   = cce_pkg::e_alu_rsh;
        imm_form = 1'b1;
      end
      // single-operand forms
      cce_pkg::e_neg_op: alu_op = cce_pkg::e_alu_neg;
      cce_pkg::e_not_op: alu_op = cce_pkg::e_alu_not;
      default: alu_op = cce_pkg::e_alu_none;
    endcase
  end

  always_comb begin
    decoded_o = '0;
    // unknown minor op leaves the fragment all zero
    if (alu_op != cce_pkg::e_alu_none) begin
      decoded_o.alu_op = alu_op;
      // dst sits in the same bits for rtype and itype
      decoded_o.dst_sel = cce_pkg::e_dst_sel_gpr;
      decoded_o.dst     = inst_i.opd.rtype.dst;
      decoded_o.gpr_w_v[inst_i.opd.rtype.dst[cce_pkg::gpr_sel_width-1:0]] = 1'b1;
      decoded_o.src_a_sel = cce_pkg::e_src_sel_gpr;
      decoded_o.src_a     = inst_i.opd.rtype.src_a;
      if (reg_form) begin
        decoded_o.src_b_sel = cce_pkg::e_src_sel_gpr;
        decoded_o.src_b     = inst_i.opd.rtype.src_b;
      end
      if (imm_form) begin
        decoded_o.src_b_sel = cce_pkg::e_src_sel_imm;
        decoded_o.imm       = inst_i.opd.itype.imm16;
      end
    end
  end

endmodule

//--- cce_branch_decode.sv
//**********************************************************
// branch class decoder
// compare op, source selects, zero-extended imm8 and target
//**********************************************************

`timescale 1ns/1ps

module cce_branch_decode (
  input  cce_pkg::cce_inst_s    inst_i,
  output cce_pkg::cce_decoded_s decoded_o
);

  cce_pkg::cce_btype_s  btype;
  cce_pkg::cce_bitype_s bitype;

  assign btype  = inst_i.opd.btype;
  assign bitype = inst_i.opd.bitype;

  always_comb begin
    decoded_o = '0;
    // target and src_a sit in the same place for btype and bitype
    decoded_o.branch_target = btype.target;
    decoded_o.src_a         = btype.src_a;
    decoded_o.src_a_sel     = cce_pkg::e_src_sel_gpr;
    decoded_o.src_b         = btype.src_b;
    decoded_o.src_b_sel     = cce_pkg::e_src_sel_gpr;
    case (inst_i.minor_op)
      cce_pkg::e_beq_op: decoded_o.branch_op = cce_pkg::e_branch_eq;
      cce_pkg::e_bne_op: decoded_o.branch_op = cce_pkg::e_branch_neq;
      cce_pkg::e_blt_op: decoded_o.branch_op = cce_pkg::e_branch_lt;
      cce_pkg::e_ble_op: decoded_o.branch_op = cce_pkg::e_branch_le;
      // special compared against a gpr
      cce_pkg::e_bs_op: begin
        decoded_o.branch_op = cce_pkg::e_branch_eq;
        decoded_o.src_a_sel = cce_pkg::e_src_sel_special;
      end
      cce_pkg::e_bss_op: begin
        decoded_o.branch_op = cce_pkg::e_branch_eq;
        decoded_o.src_a_sel = cce_pkg::e_src_sel_special;
        decoded_o.src_b_sel = cce_pkg::e_src_sel_special;
      end
      // immediate forms take imm8 as source b, no src_b register
      cce_pkg::e_beqi_op: begin
        decoded_o.branch_op = cce_pkg::e_branch_eq;
        decoded_o.src_b_sel = cce_pkg::e_src_sel_imm;
        decoded_o.src_b     = '0;
        decoded_o.imm       = {{(cce_pkg::imm16_width - cce_pkg::imm8_width){1'b0}},
                               bitype.imm8};
      end
      cce_pkg::e_bsi_op: begin
        decoded_o.branch_op = cce_pkg::e_branch_eq;
        decoded_o.src_a_sel = cce_pkg::e_src_sel_special;
        decoded_o.src_b_sel = cce_pkg::e_src_sel_imm;
        decoded_o.src_b     = '0;
        decoded_o.imm       = {{(cce_pkg::imm16_width - cce_pkg::imm8_width){1'b0}},
                               bitype.imm8};
      end
      default: decoded_o = '0;
    endcase
  end

endmodule

//--- cce_move_decode.sv
//**********************************************************
// register data move decoder
// source and destination selects, GPR, flag and special
// write enables, MSHR clear
//**********************************************************

`timescale 1ns/1ps

module cce_move_decode (
  input  cce_pkg::cce_inst_s    inst_i,
  output cce_pkg::cce_decoded_s decoded_o
);

  cce_pkg::cce_rtype_s rtype;
  cce_pkg::cce_itype_s itype;

  assign rtype = inst_i.opd.rtype;
  assign itype = inst_i.opd.itype;

  always_comb begin
    decoded_o = '0;
    // dst is common to rtype and itype, src_a only means something for rtype
    decoded_o.dst   = rtype.dst;
    decoded_o.src_a = rtype.src_a;
    case (inst_i.minor_op)
      cce_pkg::e_mov_op: begin
        decoded_o.src_a_sel = cce_pkg::e_src_sel_gpr;
        decoded_o.dst_sel   = cce_pkg::e_dst_sel_gpr;
      end
      cce_pkg::e_movsg_op: begin
        decoded_o.src_a_sel = cce_pkg::e_src_sel_special;
        decoded_o.dst_sel   = cce_pkg::e_dst_sel_gpr;
      end
      cce_pkg::e_movgs_op: begin
        decoded_o.src_a_sel = cce_pkg::e_src_sel_gpr;
        decoded_o.dst_sel   = cce_pkg::e_dst_sel_special;
      end
      cce_pkg::e_movfg_op: begin
        decoded_o.src_a_sel = cce_pkg::e_src_sel_flag;
        decoded_o.dst_sel   = cce_pkg::e_dst_sel_gpr;
      end
      cce_pkg::e_movgf_op: begin
        decoded_o.src_a_sel = cce_pkg::e_src_sel_gpr;
        decoded_o.dst_sel   = cce_pkg::e_dst_sel_flag;
      end
      cce_pkg::e_movi_op: begin
        decoded_o.src_a_sel = cce_pkg::e_src_sel_imm;
        decoded_o.src_a     = '0;
        decoded_o.imm       = itype.imm16;
        decoded_o.dst_sel   = cce_pkg::e_dst_sel_gpr;
      end
      cce_pkg::e_movis_op: begin
        decoded_o.src_a_sel = cce_pkg::e_src_sel_imm;
        decoded_o.src_a     = '0;
        decoded_o.imm       = itype.imm16;
        decoded_o.dst_sel   = cce_pkg::e_dst_sel_special;
      end
      cce_pkg::e_clm_op: begin
        decoded_o            = '0;
        decoded_o.mshr_clear = 1'b1;
      end
      default: decoded_o = '0;
    endcase

    // write enables follow from the destination kind
    case (decoded_o.dst_sel)
      cce_pkg::e_dst_sel_gpr: begin
        decoded_o.gpr_w_v[decoded_o.dst[cce_pkg::gpr_sel_width-1:0]] = 1'b1;
      end
      cce_pkg::e_dst_sel_flag: begin
        decoded_o.flag_w_v[decoded_o.dst] = 1'b1;
      end
      cce_pkg::e_dst_sel_special: begin
        decoded_o.special_w_v[decoded_o.dst] = 1'b1;
        // writing the flags special rewrites every flag
        if (decoded_o.dst == cce_pkg::opd_flags) begin
          decoded_o.flag_w_v = '1;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

//--- cce_inst_decode.sv
//**********************************************************
// decode and execute stage of the CCE microcode engine
// stage register, the three class decoders, class select
// and valid gating of the control word
//**********************************************************

`timescale 1ns/1ps

module cce_inst_decode (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  cce_pkg::cce_inst_s           inst_i,
  input  logic [cce_pkg::pc_width-1:0] pc_i,
  input  logic                         inst_v_i,
  input  logic                         stall_i,
  input  logic                         mispredict_i,
  output cce_pkg::cce_decoded_s        decoded_o,
  output logic [cce_pkg::pc_width-1:0] pc_o
);

  cce_pkg::cce_inst_s           inst_r;
  logic [cce_pkg::pc_width-1:0] pc_r;
  logic                         inst_v_r;

  cce_pkg::cce_decoded_s alu_dec;
  cce_pkg::cce_decoded_s branch_dec;
  cce_pkg::cce_decoded_s move_dec;
  cce_pkg::cce_decoded_s class_dec;

  cce_stage_reg i_stage_reg (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .inst_v_i     (inst_v_i),
    .stall_i      (stall_i),
    .mispredict_i (mispredict_i),
    .inst_o       (inst_r),
    .pc_o         (pc_r),
    .inst_v_o     (inst_v_r)
  );

  // each decoder sees the held word regardless of op and valid
  cce_alu_decode i_alu_decode (
    .inst_i    (inst_r),
    .decoded_o (alu_dec)
  );

  cce_branch_decode i_branch_decode (
    .inst_i    (inst_r),
    .decoded_o (branch_dec)
  );

  cce_move_decode i_move_decode (
    .inst_i    (inst_r),
    .decoded_o (move_dec)
  );

  always_comb begin
    case (inst_r.op)
      cce_pkg::e_op_alu:      class_dec = alu_dec;
      cce_pkg::e_op_branch:   class_dec = branch_dec;
      cce_pkg::e_op_reg_data: class_dec = move_dec;
      default:                class_dec = '0;
    endcase

    decoded_o = '0;
    if (inst_v_r) begin
      decoded_o               = class_dec;
      decoded_o.v             = 1'b1;
      decoded_o.branch        = inst_r.branch;
      decoded_o.predict_taken = inst_r.predict_taken;
      decoded_o.op            = inst_r.op;
      decoded_o.minor_op      = inst_r.minor_op;
    end
  end

  assign pc_o = pc_r;

endmodule

//--- cce_decode_chk.sv
//**********************************************************
// assertions bound to the decode stage top
// zero word when invalid, one GPR write at most, and a
// stable output across a stall
//**********************************************************

`timescale 1ns/1ps

module cce_decode_chk (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  stall_i,
  input cce_pkg::cce_decoded_s decoded_i
);

  // an invalid slot carries no control at all
  a_zero_when_invalid: assert property (@(posedge clk_i) disable iff (reset_i)
    !decoded_i.v |-> decoded_i == '0)
    else $error("decoded word not zero while v is low");

  a_gpr_write_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(decoded_i.gpr_w_v))
    else $error("more than one GPR write enable set");

  // stall holds the stage register so the decode replays unchanged
  a_stall_holds: assert property (@(posedge clk_i) disable iff (reset_i)
    stall_i |=> $stable(decoded_i))
    else $error("decoded word changed across a stall");

endmodule

bind cce_inst_decode cce_decode_chk i_decode_chk (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .stall_i   (stall_i),
  .decoded_i (decoded_o)
);

//--- tb_cce_inst_decode.sv
//**********************************************************
// testbench for the CCE decode and execute stage
// clock, reset, stimulus, reference decode and comparing
// process with its own stage-register model
//**********************************************************

`timescale 1ns/1ps

module tb_cce_inst_decode;

  logic                         clk_i;
  logic                         reset_i;
  cce_pkg::cce_inst_s           inst_i;
  logic [cce_pkg::pc_width-1:0] pc_i;
  logic                         inst_v_i;
  logic                         stall_i;
  logic                         mispredict_i;
  cce_pkg::cce_decoded_s        decoded_o;
  logic [cce_pkg::pc_width-1:0] pc_o;

  // stage register model and bookkeeping
  cce_pkg::cce_inst_s           exp_inst;
  logic [cce_pkg::pc_width-1:0] exp_pc;
  logic                         exp_v;
  cce_pkg::cce_decoded_s        exp_dec;
  int                           seed = 61627;
  int                           errors = 0;
  int                           check_count = 0;

  cce_inst_decode i_dut (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .inst_v_i     (inst_v_i),
    .stall_i      (stall_i),
    .mispredict_i (mispredict_i),
    .decoded_o    (decoded_o),
    .pc_o         (pc_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // expected control word, built from raw bit positions of the instruction
  function automatic cce_pkg::cce_decoded_s decode_ref(input cce_pkg::cce_inst_s inst,
                                                       input logic v);
    cce_pkg::cce_decoded_s d;
    logic [31:0]           w;
    logic [3:0]            m;
    d = '0;
    w = inst;
    m = w[28:25];
    if (v) begin
      d.v             = 1'b1;
      d.op            = cce_pkg::cce_op_e'(w[31:29]);
      d.minor_op      = m;
      d.branch        = w[24];
      d.predict_taken = w[23];
      case (w[31:29])
        3'd0: begin
          case (m)
            4'd0, 4'd8:  d.alu_op = cce_pkg::e_alu_add;
            4'd1, 4'd9:  d.alu_op = cce_pkg::e_alu_sub;
            4'd2, 4'd10: d.alu_op = cce_pkg::e_alu_lsh;
            4'd3, 4'd11: d.alu_op = cce_pkg::e_alu_rsh;
            4'd4:        d.alu_op = cce_pkg::e_alu_and;
            4'd5:        d.alu_op = cce_pkg::e_alu_or;
            4'd6:        d.alu_op = cce_pkg::e_alu_xor;
            4'd7:        d.alu_op = cce_pkg::e_alu_neg;
            4'd12:       d.alu_op = cce_pkg::e_alu_not;
            default:     d.alu_op = cce_pkg::e_alu_none;
          endcase
          if (m <= 4'd12) begin
            d.dst_sel   = cce_pkg::e_dst_sel_gpr;
            d.dst       = w[22:19];
            d.gpr_w_v   = 8'd1 << w[21:19];
            d.src_a_sel = cce_pkg::e_src_sel_gpr;
            d.src_a     = w[18:15];
            if (m <= 4'd6) begin
              d.src_b_sel = cce_pkg::e_src_sel_gpr;
              d.src_b     = w[14:11];
            end else if (m >= 4'd8 && m <= 4'd11) begin
              d.src_b_sel = cce_pkg::e_src_sel_imm;
              d.imm       = w[18:3];
            end
          end
        end
        3'd1: begin
          if (m <= 4'd7) begin
            d.branch_target = w[22:15];
            d.src_a         = w[14:11];
            d.src_a_sel     = cce_pkg::e_src_sel_gpr;
            d.src_b         = w[10:7];
            d.src_b_sel     = cce_pkg::e_src_sel_gpr;
            d.branch_op = (m <= 4'd3) ? cce_pkg::cce_branch_op_e'(m[1:0]) : cce_pkg::e_branch_eq;
            if (m == 4'd4 || m == 4'd5 || m == 4'd7) d.src_a_sel = cce_pkg::e_src_sel_special;
            if (m == 4'd5) d.src_b_sel = cce_pkg::e_src_sel_special;
            if (m >= 4'd6) begin
              d.src_b_sel = cce_pkg::e_src_sel_imm;
              d.src_b     = '0;
              d.imm       = {8'h00, w[10:3]};
            end
          end
        end
        3'd2: begin
          if (m == 4'd7) begin
            d.mshr_clear = 1'b1;
          end else if (m < 4'd7) begin
            d.dst   = w[22:19];
            d.src_a = w[18:15];
            case (m)
              4'd0, 4'd2, 4'd4: d.src_a_sel = cce_pkg::e_src_sel_gpr;
              4'd1:             d.src_a_sel = cce_pkg::e_src_sel_special;
              4'd3:             d.src_a_sel = cce_pkg::e_src_sel_flag;
              default: begin
                d.src_a_sel = cce_pkg::e_src_sel_imm;
                d.src_a     = '0;
                d.imm       = w[18:3];
              end
            endcase
            case (m)
              4'd2, 4'd6: d.dst_sel = cce_pkg::e_dst_sel_special;
              4'd4:       d.dst_sel = cce_pkg::e_dst_sel_flag;
              default:    d.dst_sel = cce_pkg::e_dst_sel_gpr;
            endcase
            if (d.dst_sel == cce_pkg::e_dst_sel_gpr) begin
              d.gpr_w_v = 8'd1 << w[21:19];
            end else if (d.dst_sel == cce_pkg::e_dst_sel_flag) begin
              d.flag_w_v = 16'd1 << w[22:19];
            end else begin
              d.special_w_v = 16'd1 << w[22:19];
              // flags special covers every flag
              if (w[22:19] == 4'd8) d.flag_w_v = '1;
            end
          end
        end
        default: begin
        end
      endcase
    end
    return d;
  endfunction

  function automatic cce_pkg::cce_inst_s rand_word(input logic [2:0] op, input logic [3:0] minor);
    logic [31:0] w;
    w = $random(seed);
    w[31:29] = op;
    w[28:25] = minor;
    return cce_pkg::cce_inst_s'(w);
  endfunction

  // stage register model, one cycle, reset first, stall before mispredict
  always @(posedge clk_i) begin
    if (reset_i) begin
      exp_inst <= '0;
      exp_pc   <= '0;
      exp_v    <= 1'b0;
    end else if (!stall_i) begin
      exp_inst <= inst_i;
      exp_pc   <= pc_i;
      exp_v    <= inst_v_i & ~mispredict_i;
    end
  end

  // compare in the middle of the cycle where outputs are settled,
  // starting after the first rising edge has loaded the register
  initial begin
    @(posedge clk_i);
    forever begin
      @(negedge clk_i);
      exp_dec = decode_ref(exp_inst, exp_v);
      if (decoded_o !== exp_dec) begin
        errors = errors + 1;
        $display("FAIL t=%0t decoded_o expected %h got %h", $time, exp_dec, decoded_o);
      end
      if (pc_o !== exp_pc) begin
        errors = errors + 1;
        $display("FAIL t=%0t pc_o expected %h got %h", $time, exp_pc, pc_o);
      end
      check_count = check_count + 1;
    end
  end

  // wait for the next compared cycle, then step past the edge
  task automatic next_slot();
    int start;
    int n;
    start = check_count;
    n = 0;
    while (check_count == start && n < 8) begin
      @(posedge clk_i);
      n = n + 1;
    end
    if (check_count == start) begin
      $display("timeout: the compare process made no progress");
      $display("FAIL: see errors above");
      $finish;
    end else begin
      #1;
    end
  endtask

  task automatic apply(input cce_pkg::cce_inst_s inst, input logic v, input logic stall,
                       input logic mp, input logic rst);
    logic [31:0] r;
    next_slot();
    r            = $random(seed);
    inst_i       = inst;
    pc_i         = r[7:0];
    inst_v_i     = v;
    stall_i      = stall;
    mispredict_i = mp;
    reset_i      = rst;
  endtask

  initial begin
    int                 m;
    int                 n;
    logic [31:0]        r;
    cce_pkg::cce_inst_s w;
    reset_i      = 1'b1;
    inst_i       = '0;
    pc_i         = '0;
    inst_v_i     = 1'b0;
    stall_i      = 1'b0;
    mispredict_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1 reset_i = 1'b0;

    // ALU words, register and immediate forms
    repeat (40) begin
      r = $random(seed);
      apply(rand_word(cce_pkg::e_op_alu, r[3:0] % 13), 1'b1, 1'b0, 1'b0, 1'b0);
    end
    // all eight branch kinds
    for (m = 0; m < 8; m++) begin
      repeat (4) apply(rand_word(cce_pkg::e_op_branch, m), 1'b1, 1'b0, 1'b0, 1'b0);
    end
    // every move, then movis and movgs onto the named specials
    for (m = 0; m < 8; m++) begin
      repeat (3) apply(rand_word(cce_pkg::e_op_reg_data, m), 1'b1, 1'b0, 1'b0, 1'b0);
    end
    w = rand_word(cce_pkg::e_op_reg_data, cce_pkg::e_movis_op);
    w.opd.itype.dst = cce_pkg::opd_req_lce;
    apply(w, 1'b1, 1'b0, 1'b0, 1'b0);
    w.opd.itype.dst = cce_pkg::opd_req_addr;
    apply(w, 1'b1, 1'b0, 1'b0, 1'b0);
    w.opd.itype.dst = cce_pkg::opd_flags;
    apply(w, 1'b1, 1'b0, 1'b0, 1'b0);
    w = rand_word(cce_pkg::e_op_reg_data, cce_pkg::e_movgs_op);
    w.opd.rtype.dst = cce_pkg::opd_flags;
    apply(w, 1'b1, 1'b0, 1'b0, 1'b0);

    // stall while the inputs keep changing
    apply(rand_word(cce_pkg::e_op_alu, cce_pkg::e_addi_op), 1'b1, 1'b0, 1'b0, 1'b0);
    r = $random(seed);
    n = 2 + r[1:0];
    repeat (n) begin
      r = $random(seed);
      apply(rand_word(r[1:0] % 3, r[7:4]), 1'b1, 1'b1, 1'b0, 1'b0);
    end
    apply(rand_word(cce_pkg::e_op_branch, cce_pkg::e_bne_op), 1'b1, 1'b0, 1'b0, 1'b0);

    // mispredict with stall is ignored, without stall it squashes
    apply(rand_word(cce_pkg::e_op_alu, cce_pkg::e_xor_op), 1'b1, 1'b0, 1'b0, 1'b0);
    apply(rand_word(cce_pkg::e_op_branch, cce_pkg::e_blt_op), 1'b1, 1'b1, 1'b1, 1'b0);
    apply(rand_word(cce_pkg::e_op_reg_data, cce_pkg::e_movi_op), 1'b1, 1'b0, 1'b1, 1'b0);
    apply(rand_word(cce_pkg::e_op_alu, cce_pkg::e_not_op), 1'b1, 1'b0, 1'b0, 1'b0);

    // reset mid-run, invalid ops, unknown minor ops, valid low
    apply(rand_word(cce_pkg::e_op_alu, cce_pkg::e_sub_op), 1'b1, 1'b0, 1'b0, 1'b1);
    for (m = 3; m < 8; m++) begin
      r = $random(seed);
      apply(rand_word(m, r[3:0]), 1'b1, 1'b0, 1'b0, 1'b0);
      apply(rand_word(m, r[7:4]), 1'b0, 1'b0, 1'b0, 1'b0);
    end
    for (m = 13; m < 16; m++) begin
      apply(rand_word(cce_pkg::e_op_alu, m), 1'b1, 1'b0, 1'b0, 1'b0);
      apply(rand_word(cce_pkg::e_op_branch, m - 4), 1'b1, 1'b0, 1'b0, 1'b0);
      apply(rand_word(cce_pkg::e_op_reg_data, m - 4), 1'b1, 1'b0, 1'b0, 1'b0);
    end
    repeat (6) begin
      r = $random(seed);
      apply(rand_word(r[1:0] % 3, r[7:4]), 1'b0, 1'b0, 1'b0, 1'b0);
    end
    next_slot();
    next_slot();

    $display("checks %0d, errors %0d", check_count, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- src.f
cce_pkg.sv
cce_stage_reg.sv
cce_alu_decode.sv
cce_branch_decode.sv
cce_move_decode.sv
cce_inst_decode.sv
cce_decode_chk.sv
tb_cce_inst_decode.sv
